// ==== leaf_pkg.sv ====
`default_nettype none

package leaf_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packet geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_SEQ_BITS  = 7;
    localparam int OP_BITS       = 3;
    // Whatever is left after the header and the opcode and channel fields
    localparam int CTRL_ARG_BITS = PACKET_BITS - 1 - NUM_LEAF_BITS - 2 * NUM_PORT_BITS - OP_BITS;

    // User channels and buffering
    localparam int NUM_IN_PORTS   = 2;  // Network to user
    localparam int NUM_OUT_PORTS  = 6;  // User to network
    localparam int CHAN_IDX_BITS  = $clog2(NUM_OUT_PORTS);
    localparam int FIFO_DEPTH     = 16;
    localparam int FIFO_ADDR_BITS = $clog2(FIFO_DEPTH);
    localparam int CREDIT_BITS    = 8;

    localparam logic [NUM_PORT_BITS-1:0] CTRL_PORT = '0;

    localparam logic [OP_BITS-1:0] OP_SET_DEST   = 3'd1;
    localparam logic [OP_BITS-1:0] OP_ADD_CREDIT = 3'd2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packet views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic                     valid;
        logic [NUM_LEAF_BITS-1:0] dest_leaf;
        logic [NUM_PORT_BITS-1:0] dest_port;
        logic [NUM_SEQ_BITS-1:0]  seq;
        logic [PAYLOAD_BITS-1:0]  payload;
    } leaf_data_t;

    typedef struct packed {
        logic                     valid;
        logic [NUM_LEAF_BITS-1:0] dest_leaf;
        logic [NUM_PORT_BITS-1:0] dest_port;
        logic [OP_BITS-1:0]       ctrl_op;
        logic [NUM_PORT_BITS-1:0] ctrl_chan;
        logic [CTRL_ARG_BITS-1:0] ctrl_arg;  // Dest entry in 8:0 or credit count in 7:0
    } leaf_ctrl_t;

    // Port 0 selects the control view, every other port the data view
    typedef union packed {
        leaf_data_t data;
        leaf_ctrl_t ctrl;
    } leaf_packet_t;

    typedef struct packed {
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
    } dest_entry_t;

    typedef struct packed {
        logic                     valid;
        logic [OP_BITS-1:0]       op;
        logic [NUM_PORT_BITS-1:0] chan;
        logic [CTRL_ARG_BITS-1:0] arg;
    } ctrl_cmd_t;

endpackage

`default_nettype wire

// ==== leaf_ingress.sv ====
`default_nettype none

module leaf_ingress import leaf_pkg::*; (
    input  wire                     clk,
    input  wire                     reset,
    input  wire leaf_packet_t       din_leaf_bft2interface,
    output logic [NUM_IN_PORTS-1:0] wr_en,
    output logic [PAYLOAD_BITS-1:0] wr_data,
    output ctrl_cmd_t               ctrl_cmd
);

    logic pkt_valid;
    logic is_ctrl;

    assign pkt_valid = din_leaf_bft2interface.data.valid;

    // Both views share the header, so either one could answer this
    assign is_ctrl = din_leaf_bft2interface.ctrl.dest_port == CTRL_PORT;

    always_ff @(posedge clk) begin
        wr_data       <= din_leaf_bft2interface.data.payload;
        ctrl_cmd.op   <= din_leaf_bft2interface.ctrl.ctrl_op;
        ctrl_cmd.chan <= din_leaf_bft2interface.ctrl.ctrl_chan;
        ctrl_cmd.arg  <= din_leaf_bft2interface.ctrl.ctrl_arg;

        if (reset) begin
            wr_en          <= '0;
            ctrl_cmd.valid <= 1'b0;
        end else begin
            ctrl_cmd.valid <= pkt_valid && is_ctrl;
            // Port p feeds buffer p-1, anything past the last buffer is dropped
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                wr_en[i] <= pkt_valid && !is_ctrl &&
                            din_leaf_bft2interface.data.dest_port == NUM_PORT_BITS'(i + 1);
            end
        end
    end

    // A packet ends up in at most one buffer or in the command path, never both
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({wr_en, ctrl_cmd.valid}))
        else $error("ingress sent one packet to more than one destination");

endmodule

`default_nettype wire

// ==== port_fifo.sv ====
`default_nettype none

module port_fifo import leaf_pkg::*; (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     wr_en,
    input  wire [PAYLOAD_BITS-1:0]  wr_data,
    output logic [PAYLOAD_BITS-1:0] dout_leaf_interface2user,
    output logic                    vld_interface2user,
    input  wire                     ack_user2interface
);

    logic [PAYLOAD_BITS-1:0] mem [FIFO_DEPTH];

    // One extra bit on each pointer tells full from empty
    logic [FIFO_ADDR_BITS:0] wr_ptr;
    logic [FIFO_ADDR_BITS:0] rd_ptr;
    logic                    mem_empty;
    logic                    mem_full;
    logic                    pop;

    assign mem_empty = wr_ptr == rd_ptr;
    assign mem_full  = (wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS]) &&
                       (wr_ptr[FIFO_ADDR_BITS-1:0] == rd_ptr[FIFO_ADDR_BITS-1:0]);

    // Refill the head whenever it is empty or being taken this cycle
    assign pop = !mem_empty && (!vld_interface2user || ack_user2interface);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_ADDR_BITS-1:0]] <= wr_data;
        end
        if (pop) begin
            dout_leaf_interface2user <= mem[rd_ptr[FIFO_ADDR_BITS-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr             <= '0;
            rd_ptr             <= '0;
            vld_interface2user <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (pop) begin
                rd_ptr             <= rd_ptr + 1'b1;
                vld_interface2user <= 1'b1;
            end else if (ack_user2interface) begin
                vld_interface2user <= 1'b0;  // Head taken and nothing behind it
            end
        end
    end

    // The network sender must not overrun a buffer the user is not draining
    assert property (@(posedge clk) disable iff (reset)
        wr_en && mem_full |-> pop)
        else $error("write into a full user buffer");

endmodule

`default_nettype wire

// ==== route_credit_table.sv ====
`default_nettype none

module route_credit_table import leaf_pkg::*; (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire ctrl_cmd_t                         ctrl_cmd,
    input  wire [NUM_OUT_PORTS-1:0]                consume,
    output dest_entry_t [NUM_OUT_PORTS-1:0]        dest,
    output logic [NUM_OUT_PORTS-1:0]               credit_ok
);

    logic [NUM_OUT_PORTS-1:0][CREDIT_BITS-1:0] credit;
    logic [NUM_OUT_PORTS-1:0][CREDIT_BITS:0]   credit_sum;  // One bit wider to catch overflow
    logic [NUM_OUT_PORTS-1:0]                  cmd_hit;

    // Channel j of the table answers to channel number j+1 in a command
    always_comb begin
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            cmd_hit[j] = ctrl_cmd.valid && ctrl_cmd.chan == NUM_PORT_BITS'(j + 1);
        end
    end

    // New credits and a consume in the same cycle both count
    always_comb begin
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            credit_sum[j] = {1'b0, credit[j]} - consume[j];
            if (cmd_hit[j] && ctrl_cmd.op == OP_ADD_CREDIT) begin
                credit_sum[j] = credit_sum[j] + ctrl_cmd.arg[CREDIT_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credit <= '0;
            dest   <= '0;
        end else begin
            for (int j = 0; j < NUM_OUT_PORTS; j++) begin
                // Saturate rather than wrap
                if (credit_sum[j][CREDIT_BITS]) begin
                    credit[j] <= '1;
                end else begin
                    credit[j] <= credit_sum[j][CREDIT_BITS-1:0];
                end

                if (cmd_hit[j] && ctrl_cmd.op == OP_SET_DEST) begin
                    dest[j] <= ctrl_cmd.arg[NUM_LEAF_BITS+NUM_PORT_BITS-1:0];
                end
            end
        end
    end

    always_comb begin
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            credit_ok[j] = credit[j] != '0;
        end
    end

    // Egress may only spend credit that the table has granted
    assert property (@(posedge clk) disable iff (reset)
        (consume & ~credit_ok) == '0)
        else $error("consume on a channel with no credit");

endmodule

`default_nettype wire

// ==== leaf_egress.sv ====
`default_nettype none

module leaf_egress import leaf_pkg::*; (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire                                        resend,
    input  wire [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0]  din_leaf_user2interface,
    input  wire [NUM_OUT_PORTS-1:0]                    vld_user2interface,
    output logic [NUM_OUT_PORTS-1:0]                   ack_interface2user,
    input  wire dest_entry_t [NUM_OUT_PORTS-1:0]       dest,
    input  wire [NUM_OUT_PORTS-1:0]                    credit_ok,
    output logic [NUM_OUT_PORTS-1:0]                   consume,
    output leaf_packet_t                               dout_leaf_interface2bft
);

    logic [NUM_OUT_PORTS-1:0]                   req;
    logic [CHAN_IDX_BITS-1:0]                   last_grant;
    logic [CHAN_IDX_BITS-1:0]                   grant_idx;
    logic                                       grant_any;
    logic [NUM_OUT_PORTS-1:0][NUM_SEQ_BITS-1:0] seq;
    leaf_packet_t                               pkt_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin arbiter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign req = vld_user2interface & credit_ok & {NUM_OUT_PORTS{!resend}};

    // Search starts one past the last grant and wraps around once
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_idx = last_grant;
        for (int k = 1; k <= NUM_OUT_PORTS; k++) begin
            idx = int'(last_grant) + k;
            if (idx >= NUM_OUT_PORTS) idx = idx - NUM_OUT_PORTS;
            if (!grant_any && req[idx]) begin
                grant_any = 1'b1;
                grant_idx = CHAN_IDX_BITS'(idx);
            end
        end
    end

    assign ack_interface2user = grant_any ? NUM_OUT_PORTS'(1) << grant_idx : '0;
    assign consume            = ack_interface2user;  // Every ack spends one credit

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packet assembly
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= CHAN_IDX_BITS'(NUM_OUT_PORTS - 1);  // First search begins at channel 0
            seq        <= '0;
            pkt_q      <= '0;
        end else begin
            pkt_q <= '0;
            if (grant_any) begin
                last_grant     <= grant_idx;
                seq[grant_idx] <= seq[grant_idx] + 1'b1;
                pkt_q.data     <= '{valid:     1'b1,
                                    dest_leaf: dest[grant_idx].leaf,
                                    dest_port: dest[grant_idx].port,
                                    seq:       seq[grant_idx],
                                    payload:   din_leaf_user2interface[grant_idx]};
            end
        end
    end

    // The network sees nothing at all while it asks for a resend
    assign dout_leaf_interface2bft = resend ? '0 : pkt_q;

endmodule

`default_nettype wire

// ==== leaf_node.sv ====
`default_nettype none

module leaf_node import leaf_pkg::*; (
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire                                       resend,

    // Network side
    input  wire leaf_packet_t                         din_leaf_bft2interface,
    output wire leaf_packet_t                         dout_leaf_interface2bft,

    // Toward the user kernel
    output wire [NUM_IN_PORTS-1:0][PAYLOAD_BITS-1:0]  dout_leaf_interface2user,
    output wire [NUM_IN_PORTS-1:0]                    vld_interface2user,
    input  wire [NUM_IN_PORTS-1:0]                    ack_user2interface,

    // From the user kernel
    input  wire [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] din_leaf_user2interface,
    input  wire [NUM_OUT_PORTS-1:0]                   vld_user2interface,
    output wire [NUM_OUT_PORTS-1:0]                   ack_interface2user
);

    wire [NUM_IN_PORTS-1:0]                wr_en;
    wire [PAYLOAD_BITS-1:0]                wr_data;
    wire ctrl_cmd_t                        ctrl_cmd;
    wire dest_entry_t [NUM_OUT_PORTS-1:0]  dest;
    wire [NUM_OUT_PORTS-1:0]               credit_ok;
    wire [NUM_OUT_PORTS-1:0]               consume;

    leaf_ingress ingress_inst (
        .clk                    (clk),
        .reset                  (reset),
        .din_leaf_bft2interface (din_leaf_bft2interface),
        .wr_en                  (wr_en),
        .wr_data                (wr_data),
        .ctrl_cmd               (ctrl_cmd)
    );

    // One buffer per user output channel, all fed from the same write data
    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_port
        port_fifo port_fifo_inst (
            .clk                      (clk),
            .reset                    (reset),
            .wr_en                    (wr_en[i]),
            .wr_data                  (wr_data),
            .dout_leaf_interface2user (dout_leaf_interface2user[i]),
            .vld_interface2user       (vld_interface2user[i]),
            .ack_user2interface       (ack_user2interface[i])
        );
    end

    route_credit_table table_inst (
        .clk       (clk),
        .reset     (reset),
        .ctrl_cmd  (ctrl_cmd),
        .consume   (consume),
        .dest      (dest),
        .credit_ok (credit_ok)
    );

    leaf_egress egress_inst (
        .clk                     (clk),
        .reset                   (reset),
        .resend                  (resend),
        .din_leaf_user2interface (din_leaf_user2interface),
        .vld_user2interface      (vld_user2interface),
        .ack_interface2user      (ack_interface2user),
        .dest                    (dest),
        .credit_ok               (credit_ok),
        .consume                 (consume),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

// ==== tb_leaf_node.sv ====
`default_nettype none

module tb_leaf_node import leaf_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_REC    = 64;
    localparam int CLK_HALF   = 50;
    localparam int K_NET_IN   = 1;  // Record kinds of the golden file
    localparam int K_USER_IN  = 2;
    localparam int K_RESEND   = 3;
    localparam int K_EXP_NET  = 4;
    localparam int K_EXP_USER = 5;

    logic                                       clk;
    logic                                       reset;
    logic                                       resend;
    leaf_packet_t                               din_leaf_bft2interface;
    leaf_packet_t                               dout_leaf_interface2bft;
    logic [NUM_IN_PORTS-1:0][PAYLOAD_BITS-1:0]  dout_leaf_interface2user;
    logic [NUM_IN_PORTS-1:0]                    vld_interface2user;
    logic [NUM_IN_PORTS-1:0]                    ack_user2interface;
    logic [NUM_OUT_PORTS-1:0][PAYLOAD_BITS-1:0] din_leaf_user2interface;
    logic [NUM_OUT_PORTS-1:0]                   vld_user2interface;
    logic [NUM_OUT_PORTS-1:0]                   ack_interface2user;

    logic [51:0] golden [4*MAX_REC];  // Four words per record
    int num_rec;
    int last_step;
    int errors;
    int checks;
    int cycle;
    bit loaded;

    // Record indices per channel, consumed from pos up to cnt
    int word_rec [NUM_OUT_PORTS][MAX_REC];
    int word_cnt [NUM_OUT_PORTS];
    int word_pos [NUM_OUT_PORTS];
    int net_rec [NUM_OUT_PORTS][MAX_REC];
    int net_cnt [NUM_OUT_PORTS];
    int net_pos [NUM_OUT_PORTS];
    int user_rec [NUM_IN_PORTS][MAX_REC];
    int user_cnt [NUM_IN_PORTS];
    int user_pos [NUM_IN_PORTS];

    bit [NUM_OUT_PORTS-1:0] took;   // Handshakes seen at the last falling edge
    int credit_model [NUM_OUT_PORTS];
    int last_grant;
    int due_chan;                   // Channel whose packet should be on the network now
    leaf_packet_t cmd_stage;

    leaf_node dut (
        .clk                      (clk),
        .reset                    (reset),
        .resend                   (resend),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2bft  (dout_leaf_interface2bft),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

    function automatic int rec_field(input int r, input int f);
        return int'(golden[4*r+f]);
    endfunction

    function automatic logic [51:0] rec_value(input int r);
        return golden[4*r+3];
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("** Error at cycle %0d: %s = %h, expected %h", cycle, name, got, exp);
    endtask

    task automatic load_golden();
        int kind;
        int chan;
        for (int i = 0; i < 4 * MAX_REC; i++) begin
            golden[i] = '0;
        end
        $readmemh("leaf_golden.txt", golden);
        while (num_rec < MAX_REC && golden[4*num_rec] != '0) begin
            num_rec++;
        end
        for (int r = 0; r < num_rec; r++) begin
            kind = rec_field(r, 0);
            chan = rec_field(r, 2);
            if (rec_field(r, 1) > last_step) last_step = rec_field(r, 1);
            if (chan >= NUM_OUT_PORTS || (kind == K_EXP_USER && chan >= NUM_IN_PORTS)) begin
                errors++;
                $display("Golden record %0d names channel %0d, which does not exist", r, chan);
            end else if (kind == K_USER_IN) begin
                word_rec[chan][word_cnt[chan]] = r;
                word_cnt[chan]++;
            end else if (kind == K_EXP_NET) begin
                net_rec[chan][net_cnt[chan]] = r;
                net_cnt[chan]++;
            end else if (kind == K_EXP_USER) begin
                user_rec[chan][user_cnt[chan]] = r;
                user_cnt[chan]++;
            end
        end
        if (num_rec == 0) begin
            errors++;
            $display("No records could be read from leaf_golden.txt");
        end
    endtask

    function automatic bit all_consumed();
        bit done;
        done = 1'b1;
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            if (word_pos[j] != word_cnt[j] || net_pos[j] != net_cnt[j]) done = 1'b0;
        end
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            if (user_pos[i] != user_cnt[i]) done = 1'b0;
        end
        return done;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus, applied just after each rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_cycle();
        logic [51:0] v;
        logic [31:0] rnd;
        din_leaf_bft2interface = '0;
        for (int r = 0; r < num_rec; r++) begin
            v = rec_value(r);
            if (rec_field(r, 1) == cycle && rec_field(r, 0) == K_NET_IN) begin
                din_leaf_bft2interface = v[PACKET_BITS-1:0];
            end else if (rec_field(r, 1) == cycle && rec_field(r, 0) == K_RESEND) begin
                resend = v[0];
            end
        end
        for (int j = 0; j < NUM_OUT_PORTS; j++) begin
            if (took[j]) begin
                vld_user2interface[j] = 1'b0;  // Word accepted, move to the next one
                word_pos[j]++;
                took[j] = 1'b0;
            end
            if (!vld_user2interface[j] && word_pos[j] < word_cnt[j] &&
                rec_field(word_rec[j][word_pos[j]], 1) <= cycle) begin
                v = rec_value(word_rec[j][word_pos[j]]);
                din_leaf_user2interface[j] = v[PAYLOAD_BITS-1:0];
                vld_user2interface[j]      = 1'b1;
            end
        end
        rnd = $urandom;
        ack_user2interface = rnd[NUM_IN_PORTS-1:0];
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks in the middle of each cycle, where every signal is settled
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin : monitor
        logic [NUM_OUT_PORTS-1:0] exp_ack;
        logic [51:0]              v;
        int                       grant;
        int                       idx;
        int                       chan;
        if (!reset) begin
            checks++;
            if (due_chan < 0) begin
                if (dout_leaf_interface2bft !== '0) begin
                    report_mismatch("dout_leaf_interface2bft", dout_leaf_interface2bft, 0);
                end
            end else if (net_pos[due_chan] >= net_cnt[due_chan]) begin
                errors++;
                $display("Cycle %0d: channel %0d sent more packets than expected", cycle, due_chan);
            end else begin
                v = rec_value(net_rec[due_chan][net_pos[due_chan]]);
                if (dout_leaf_interface2bft !== v[PACKET_BITS-1:0]) begin
                    report_mismatch("dout_leaf_interface2bft", dout_leaf_interface2bft, v);
                end
                net_pos[due_chan]++;
            end

            // Search starts one past the last grant among channels with credit
            grant = -1;
            for (int k = 1; k <= NUM_OUT_PORTS; k++) begin
                idx = (last_grant + k) % NUM_OUT_PORTS;
                if (grant < 0 && vld_user2interface[idx] && credit_model[idx] > 0 && !resend) begin
                    grant = idx;
                end
            end
            exp_ack = '0;
            if (grant >= 0) exp_ack[grant] = 1'b1;
            if (ack_interface2user !== exp_ack) begin
                report_mismatch("ack_interface2user", ack_interface2user, exp_ack);
            end
            if (grant >= 0) begin
                last_grant = grant;
                credit_model[grant]--;
            end
            due_chan = grant;
            took     = vld_user2interface & ack_interface2user;

            // A credit packet seen last cycle counts from the cycle after next
            chan = int'(cmd_stage.ctrl.ctrl_chan);
            if (cmd_stage.ctrl.valid && cmd_stage.ctrl.dest_port == CTRL_PORT &&
                cmd_stage.ctrl.ctrl_op == OP_ADD_CREDIT && chan >= 1 && chan <= NUM_OUT_PORTS) begin
                credit_model[chan-1] += int'(cmd_stage.ctrl.ctrl_arg[CREDIT_BITS-1:0]);
                if (credit_model[chan-1] > (1 << CREDIT_BITS) - 1) begin
                    credit_model[chan-1] = (1 << CREDIT_BITS) - 1;
                end
            end
            cmd_stage = din_leaf_bft2interface;

            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                if (vld_interface2user[i] && ack_user2interface[i]) begin
                    checks++;
                    if (user_pos[i] >= user_cnt[i]) begin
                        errors++;
                        $display("Cycle %0d: user channel %0d delivered an extra word", cycle, i);
                    end else begin
                        v = rec_value(user_rec[i][user_pos[i]]);
                        if (dout_leaf_interface2user[i] !== v[PAYLOAD_BITS-1:0]) begin
                            report_mismatch($sformatf("dout_leaf_interface2user[%0d]", i),
                                            dout_leaf_interface2user[i], v);
                        end
                        user_pos[i]++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat ((num_rec + 1) * 20) @(posedge clk);
        $display("Timeout: expected traffic still outstanding after %0d cycles", cycle);
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        reset                   = 1'b1;
        resend                  = 1'b0;
        din_leaf_bft2interface  = '0;
        ack_user2interface      = '0;
        din_leaf_user2interface = '0;
        vld_user2interface      = '1;  // Every channel asks while no credit exists yet
        took                    = '0;
        cmd_stage               = '0;
        due_chan                = -1;
        last_grant              = NUM_OUT_PORTS - 1;  // First search begins at channel 0
        void'($urandom(32'h5b60_24bb));
        load_golden();
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        checks++;
        if (vld_interface2user !== '0) report_mismatch("vld_interface2user", vld_interface2user, 0);
        if (ack_interface2user !== '0) report_mismatch("ack_interface2user", ack_interface2user, 0);
        if (dout_leaf_interface2bft !== '0) begin
            report_mismatch("dout_leaf_interface2bft", dout_leaf_interface2bft, 0);
        end
        vld_user2interface = '0;
        reset = 1'b0;
        drive_cycle();
        while (cycle <= last_step || !all_consumed()) begin
            @(posedge clk);
            #1;
            cycle++;
            drive_cycle();
        end
        repeat (3) @(posedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== leaf_golden.txt ====
// kind step chan value, all hex; kinds 1 network packet in, 2 user word in, 3 resend level,
// 4 expected network packet, 5 expected user word; chan counts from 0
2 0 0 0_0000_aaaa0001
2 0 0 0_0000_aaaa0002
2 0 0 0_0000_aaaa0003
1 1 0 1_1811_00000072
1 2 0 1_1821_00000002
1 3 0 1_1880_11110001
1 4 0 1_1900_22220001
1 5 0 1_1880_11110002
1 8 0 0_1880_99999999
1 9 0 1_1900_22220002
1 a 0 1_1821_00000001
1 b 0 1_1880_11110003
1 e 0 1_1812_00000091
1 f 0 1_1822_00000003
1 10 0 1_1813_000000a3
1 11 0 1_1823_00000003
1 12 0 1_1815_00000045
1 13 0 1_1825_00000003
2 16 1 0_0000_bbbb0001
2 16 1 0_0000_bbbb0002
2 16 2 0_0000_cccc0001
2 16 2 0_0000_cccc0002
2 16 4 0_0000_dddd0001
2 16 4 0_0000_dddd0002
3 1e 0 0_0000_00000001
2 1f 2 0_0000_cccc0003
2 1f 4 0_0000_dddd0003
3 24 0 0_0000_00000000
4 0 0 1_3900_aaaa0001
4 0 0 1_3901_aaaa0002
4 0 0 1_3902_aaaa0003
4 0 1 1_4880_bbbb0001
4 0 1 1_4881_bbbb0002
4 0 2 1_5180_cccc0001
4 0 2 1_5181_cccc0002
4 0 2 1_5182_cccc0003
4 0 4 1_2280_dddd0001
4 0 4 1_2281_dddd0002
4 0 4 1_2282_dddd0003
5 0 0 0_0000_11110001
5 0 0 0_0000_11110002
5 0 0 0_0000_11110003
5 0 1 0_0000_22220001
5 0 1 0_0000_22220002

// ==== src.f ====
leaf_pkg.sv
leaf_ingress.sv
port_fifo.sv
route_credit_table.sv
leaf_egress.sv
leaf_node.sv
tb_leaf_node.sv
